//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_divider
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
div_pkg.sv
div_ctrl_if.sv
div_datapath.sv
div_controller.sv
div_result.sv
divider_top.sv
divider_assertions.sv
tb_divider.sv

//--- div_controller.sv
// Divider sequencer: start/ack handshake into load, step, capture and present strobes
`timescale 1ns/1ps

module div_controller (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  logic    ack,
    output logic    busy,
    output logic    done,
    output logic    capture,
    output logic    present,
    div_ctrl_if.ctrl bus
);
    import div_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0, // Waiting for start
        ST_ITERATE = 2'd1, // One step per clock
        ST_HOLD    = 2'd2  // Result held until ack
    } state_t;

    state_t state_q;
    state_t state_d;

    // Next-state logic
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_ITERATE;
                end
            end
            ST_ITERATE: begin
                // Leave once the final step is written
                if (bus.last_step) begin
                    state_d = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (ack) begin
                    state_d = ST_IDLE; // Outputs drop at this edge
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Start outside idle is simply ignored
    assign bus.load = (state_q == ST_IDLE) && start;
    assign bus.step = (state_q == ST_ITERATE);

    // Negative trial difference means restore
    assign bus.alu_op = bus.sub_neg ? ALU_RESTORE : ALU_COMMIT;

    // Final ALU output is what the result stage keeps
    assign capture = bus.step && bus.last_step;
    assign present = (state_q == ST_HOLD);

    // Handshake levels
    assign busy = (state_q == ST_ITERATE);
    assign done = present;

endmodule

//--- div_ctrl_if.sv
// Divider control bus: controller strobes to the datapath and datapath status back
`timescale 1ns/1ps

interface div_ctrl_if;
    import div_pkg::*;

    // Controller to datapath
    logic    load;      // Take operands, clear remainder and counter
    logic    step;      // One shift-subtract-restore iteration
    alu_op_t alu_op;    // Restore or commit for this step

    // Datapath to controller
    logic    sub_neg;   // Trial difference is negative
    logic    last_step; // Counter sits on the final iteration

    // ALU results, read by datapath and result stage
    data_t   a_next;    // Next partial remainder
    data_t   q_next;    // Next quotient

    modport ctrl (
        output load,
        output step,
        output alu_op,
        input  sub_neg,
        input  last_step
    );

    modport dp (
        input  load,
        input  step,
        input  alu_op,
        output sub_neg,
        output last_step,
        output a_next,
        output q_next
    );

    // Result stage only watches the ALU outputs
    modport res (
        input a_next,
        input q_next
    );

endinterface

//--- div_datapath.sv
// Restoring divider datapath: operand registers, iteration counter and shift-subtract ALU
`timescale 1ns/1ps

module div_datapath (
    input  logic           clk,
    input  logic           rst_n,
    input  div_pkg::data_t dividend,
    input  div_pkg::data_t divisor,
    div_ctrl_if.dp         bus
);
    import div_pkg::*;

    data_t  m_q;     // Divisor
    data_t  q_q;     // Quotient that starts out as the dividend
    data_t  a_q;     // Partial remainder
    count_t count_q; // Steps taken so far

    // One bit wider than the operands so the trial difference carries a sign
    logic [DIV_WIDTH:0] a_shift;
    logic [DIV_WIDTH:0] diff;

    // Shift {A, Q} left by one with the MSB of Q moving into A
    assign a_shift = {a_q, q_q[DIV_WIDTH-1]};

    // Trial subtraction against the divisor
    assign diff = a_shift - {1'b0, m_q};

    // A < M before the shift keeps a non-negative difference below 2^16
    // and leaves bit 16 alone to tell the sign
    assign bus.sub_neg = diff[DIV_WIDTH];

    // Final iteration flag for the controller
    assign bus.last_step = (count_q == count_t'(DIV_WIDTH - 1));

    // ALU select
    always_comb begin
        if (bus.alu_op == ALU_COMMIT) begin
            bus.a_next = diff[DIV_WIDTH-1:0];    // Subtraction stands
        end else begin
            bus.a_next = a_shift[DIV_WIDTH-1:0]; // Restore keeps the shifted value within 16 bits
        end
        // Quotient shifts left and takes the op encoding as its new LSB
        bus.q_next = {q_q[DIV_WIDTH-2:0], bus.alu_op == ALU_COMMIT};
    end

    // Divisor only changes on load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_q <= '0;
        end else if (bus.load) begin
            m_q <= divisor;
        end
    end

    // Quotient and partial remainder
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_q <= '0;
            a_q <= '0;
        end else if (bus.load) begin
            q_q <= dividend; // Dividend bits get shifted out as quotient bits come in
            a_q <= '0;
        end else if (bus.step) begin
            q_q <= bus.q_next;
            a_q <= bus.a_next;
        end
    end

    // Iteration counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (bus.load) begin
            count_q <= '0;
        end else if (bus.step) begin
            count_q <= count_q + 1'b1; // Wraps past DIV_WIDTH only if stepped further
        end
    end

endmodule

//--- div_pkg.sv
// Divider package: operand widths, data and counter types, ALU operation encoding
package div_pkg;

    // Operand width, dividend and divisor share it
    localparam int DIV_WIDTH = 16;

    // Counter has to reach DIV_WIDTH, hence one extra bit of range
    localparam int COUNT_WIDTH = $clog2(DIV_WIDTH + 1);

    // Dividend, divisor, quotient, remainder
    typedef logic [DIV_WIDTH-1:0] data_t;

    // Iteration counter
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // Per-step choice between restore and commit
    // Encoding doubles as the quotient bit shifted in
    typedef enum logic {
        ALU_RESTORE = 1'b0, // Keep shifted remainder, quotient bit 0
        ALU_COMMIT  = 1'b1  // Take difference, quotient bit 1
    } alu_op_t;

endpackage

//--- div_result.sv
// Divider result stage: captures the last ALU output and gates it until presented
`timescale 1ns/1ps

module div_result (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           capture,
    input  logic           present,
    div_ctrl_if.res        bus,
    output div_pkg::data_t quotient,
    output div_pkg::data_t remainder
);
    import div_pkg::*;

    data_t quot_q; // Held quotient
    data_t rem_q;  // Held remainder

    // Snapshot on the final step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quot_q <= '0;
            rem_q  <= '0;
        end else if (capture) begin
            quot_q <= bus.q_next;
            rem_q  <= bus.a_next;
        end
    end

    // Zero while no result is on offer
    assign quotient  = present ? quot_q : '0;
    assign remainder = present ? rem_q  : '0;

endmodule

//--- divider_assertions.sv
// Divider protocol assertions bound to the top level
`timescale 1ns/1ps

module divider_assertions (
    input logic           clk,
    input logic           rst_n,
    input logic           start,
    input logic           ack,
    input logic           busy,
    input logic           done,
    input div_pkg::data_t quotient,
    input div_pkg::data_t remainder
);
    import div_pkg::*;

    localparam int LATENCY = DIV_WIDTH + 1; // Sampling edge to done sampled high

    logic accepted;
    assign accepted = start && !busy && !done; // Start only counts while idle

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && busy))
        else $error("busy and done high together");

    a_done_held: assert property (@(posedge clk) disable iff (!rst_n)
        done && !ack |=> done)
        else $error("done fell without ack");

    a_zero_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !done |-> (quotient == '0) && (remainder == '0))
        else $error("result nonzero while done low");

    // Done rises only at the fixed latency after an accepted start
    a_rise_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(accepted, LATENCY))
        else $error("done rose without a start at the expected latency");

    a_start_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accepted, LATENCY) |-> $rose(done))
        else $error("done missing at the expected latency after start");

endmodule

bind divider_top divider_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .ack       (ack),
    .busy      (busy),
    .done      (done),
    .quotient  (quotient),
    .remainder (remainder)
);

//--- divider_top.sv
// 16-bit unsigned restoring divider top level with start/busy/done/ack handshake
`timescale 1ns/1ps

module divider_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,     // One-cycle request
    input  logic           ack,       // One-cycle result acknowledge
    input  div_pkg::data_t dividend,
    input  div_pkg::data_t divisor,
    output logic           busy,      // Iterating
    output logic           done,      // Result valid, held until ack
    output div_pkg::data_t quotient,
    output div_pkg::data_t remainder
);

    // Controller to result stage
    logic capture;
    logic present;

    // Controller and datapath share this bus
    div_ctrl_if u_bus ();

    div_controller u_controller (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .ack     (ack),
        .busy    (busy),
        .done    (done),
        .capture (capture),
        .present (present),
        .bus     (u_bus.ctrl)
    );

    div_datapath u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .dividend (dividend),
        .divisor  (divisor),
        .bus      (u_bus.dp)
    );

    // Reads the ALU outputs directly off the bus
    div_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture   (capture),
        .present   (present),
        .bus       (u_bus.res),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

//--- tb_divider.sv
// Directed testbench for the 16-bit restoring divider with handshake and latency checks
`timescale 1ns/1ps

module tb_divider;
    import div_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int LATENCY         = DIV_WIDTH + 1; // Sampling edge plus one edge per quotient bit
    localparam int DONE_LIMIT      = 40;            // Bound on any single wait for done
    localparam int NUM_RANDOM      = 200;
    localparam int NUM_DIVISIONS   = 5 + NUM_RANDOM + 2 + 2;
    localparam int WATCHDOG_CYCLES = NUM_DIVISIONS * 40;
    localparam int HOLD_CYCLES     = 50;            // Result held this long before ack

    logic  clk;
    logic  rst_n;
    logic  start;
    logic  ack;
    data_t dividend;
    data_t divisor;
    logic  busy;
    logic  done;
    data_t quotient;
    data_t remainder;

    logic [31:0] rng_state; // Xorshift state

    divider_top u_divider_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .ack       (ack),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (busy),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Ends the run if the tests stall
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all divisions finished");
        abort_run();
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Zero divisor: every trial subtraction succeeds
    function automatic data_t expected_quotient(input data_t a, input data_t b);
        if (b == '0) begin
            return '1;
        end else begin
            return a / b;
        end
    endfunction

    // Zero divisor leaves the dividend in the remainder
    function automatic data_t expected_remainder(input data_t a, input data_t b);
        if (b == '0) begin
            return a;
        end else begin
            return a % b;
        end
    endfunction

    // Present operands with a one-cycle start, called on a falling edge
    task automatic launch(input data_t a, input data_t b);
        dividend = a;
        divisor  = b;
        start    = 1'b1;
        @(posedge clk);   // Start sampled here
        @(negedge clk);
        start = 1'b0;
        check_value("busy", 32'(busy), 32'd1);
    endtask

    // Counts edges until done is seen; cycles holds edges already passed since start
    task automatic wait_done(inout int cycles);
        while (!done && cycles < DONE_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        if (!done) begin
            $display("done did not rise within %0d cycles of start", DONE_LIMIT);
            abort_run();
        end
    endtask

    task automatic check_result(input data_t a, input data_t b);
        check_value("quotient", 32'(quotient), 32'(expected_quotient(a, b)));
        check_value("remainder", 32'(remainder), 32'(expected_remainder(a, b)));
        check_value("busy", 32'(busy), 32'd0); // Never together with done
    endtask

    // One-cycle ack, outputs must drop at that same edge
    task automatic ack_result();
        ack = 1'b1;
        @(posedge clk);
        @(negedge clk);
        ack = 1'b0;
        check_value("done", 32'(done), 32'd0);
        check_value("quotient", 32'(quotient), 32'd0);
        check_value("remainder", 32'(remainder), 32'd0);
    endtask

    task automatic run_division(input data_t a, input data_t b);
        int cycles;
        launch(a, b);
        cycles = 1;
        wait_done(cycles);
        check_value("latency", 32'(cycles), 32'(LATENCY));
        check_result(a, b);
        ack_result();
    endtask

    task automatic test_reset_state();
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("quotient", 32'(quotient), 32'd0);
        check_value("remainder", 32'(remainder), 32'd0);
    endtask

    task automatic test_directed();
        run_division(16'd100, 16'd7);
        run_division(16'd65535, 16'd1);
        run_division(16'd5, 16'd9);       // Divisor above dividend
        run_division(16'd65535, 16'd65535);
        run_division(16'd0, 16'd3);
    endtask

    task automatic test_random();
        data_t a;
        data_t b;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            a = rng_state[15:0];
            b = rng_state[31:16];
            if (b == '0) begin
                b = 16'd1; // Zero divisor has its own test
            end
            run_division(a, b);
        end
    endtask

    task automatic test_divide_by_zero();
        run_division(16'h1234, 16'd0);
        run_division(16'hffff, 16'd0);
    endtask

    // Stray starts while busy and while done must change nothing
    task automatic test_ignored_start();
        int cycles;
        launch(16'd1000, 16'd13);
        cycles = 1;
        repeat (5) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        dividend = 16'd7;   // Operands change under a dropped start
        divisor  = 16'd2;
        start    = 1'b1;
        @(posedge clk);
        cycles++;
        @(negedge clk);
        start = 1'b0;
        wait_done(cycles);
        check_value("latency", 32'(cycles), 32'(LATENCY));
        check_result(16'd1000, 16'd13);
        dividend = 16'd50;
        divisor  = 16'd5;
        start    = 1'b1;    // Start during done
        @(posedge clk);
        @(negedge clk);
        start = 1'b0;
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            check_value("done", 32'(done), 32'd1);
            check_result(16'd1000, 16'd13);
            @(posedge clk);
            @(negedge clk);
        end
        ack_result();
        run_division(16'd500, 16'd7); // Back to normal operation
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        ack       = 1'b0;
        dividend  = '0;
        divisor   = '0;
        rng_state = 32'd1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_directed();
        test_random();
        test_divide_by_zero();
        test_ignored_start();
        $display("TB PASSED");
        $finish;
    end

endmodule
